//--- bus_decode.sv
// address decoder for the mailbox register windows
// one request per cycle at most, no back-pressure, one cycle of latency
// writes to the status register or to unmapped space are dropped silently
// reads from unmapped space raise o_dec_err instead of a queue strobe

module bus_decode (
	input  logic                              i_core_clk,
	input  logic                              i_rst_n,
	input  logic                              i_req,
	input  logic                              i_we,
	input  mbox_pkg::addr_t                   i_addr,
	input  mbox_pkg::data_t                   i_wdata,
	output logic [mbox_pkg::NUM_QUEUES-1:0]   o_push,
	output logic [mbox_pkg::NUM_QUEUES-1:0]   o_pop,
	output logic [mbox_pkg::NUM_QUEUES-1:0]   o_stat_rd,
	output mbox_pkg::data_t                   o_wdata,
	output logic                              o_dec_err
);

	logic [mbox_pkg::NUM_QUEUES-1:0] data_hit;
	logic [mbox_pkg::NUM_QUEUES-1:0] stat_hit;
	logic                            any_hit;

	// window match per queue
	always_comb begin
		mbox_pkg::addr_t win_base;
		mbox_pkg::addr_t win_ofs;
		data_hit = '0;
		stat_hit = '0;
		for (int k = 0; k < mbox_pkg::NUM_QUEUES; k++) begin
			win_base = mbox_pkg::MBOX_BASE + mbox_pkg::addr_t'(k) * mbox_pkg::QUEUE_STRIDE;
			win_ofs  = i_addr - win_base;
			if (i_addr >= win_base && win_ofs < mbox_pkg::QUEUE_STRIDE) begin
				data_hit[k] = (win_ofs == mbox_pkg::OFS_DATA);
				stat_hit[k] = (win_ofs == mbox_pkg::OFS_STAT);
			end
		end
	end

	assign any_hit = |{data_hit, stat_hit};

	always_ff @(posedge i_core_clk) begin
		if (!i_rst_n) begin
			o_push    <= '0;
			o_pop     <= '0;
			o_stat_rd <= '0;
			o_dec_err <= 1'b0;
		end else begin
			o_push    <= (i_req && i_we) ? data_hit : '0;
			o_pop     <= (i_req && !i_we) ? data_hit : '0;
			o_stat_rd <= (i_req && !i_we) ? stat_hit : '0;
			// only reads report a miss
			o_dec_err <= i_req && !i_we && !any_hit;
		end
	end

	// write data follows the push strobe into the queues
	always_ff @(posedge i_core_clk) begin
		o_wdata <= i_wdata;
	end

	a_one_strobe: assert property (@(posedge i_core_clk) disable iff (!i_rst_n)
		$onehot0({o_push, o_pop, o_stat_rd, o_dec_err}));

endmodule

//--- mbox_pkg.sv
// address map, queue sizes and width types shared by the mailbox blocks
// queue windows sit back to back from MBOX_BASE, one QUEUE_STRIDE each
// MBOX_BASE must be aligned to QUEUE_STRIDE so that windows never overlap
// CNT_W must be wide enough to hold QUEUE_DEPTH itself, not just DEPTH-1
// status word is {ovf, zeros, count} with the count in the low CNT_W bits

package mbox_pkg;

	// queue geometry
	localparam int NUM_QUEUES  = 2;
	localparam int QUEUE_DEPTH = 8;
	localparam int CNT_W       = 4;

	// storage index width and the slot where the pointers wrap
	localparam int PTR_W = $clog2(QUEUE_DEPTH);
	localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(QUEUE_DEPTH - 1);

	// bus address, message word and fill count
	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;
	typedef logic [CNT_W-1:0] count_t;

	// queue 0 window; queue k is at MBOX_BASE + k * QUEUE_STRIDE
	localparam addr_t MBOX_BASE    = 32'hF100_1000;
	localparam addr_t QUEUE_STRIDE = 32'h0000_1000;

	// register offsets inside a window
	localparam addr_t OFS_DATA = 32'h0000_0000;
	localparam addr_t OFS_STAT = 32'h0000_0004;

	// overflow flag position in the status word
	localparam int STAT_OVF_BIT = 31;

endpackage

//--- mbox_top.sv
// two-queue mailbox, strobe bus in, strobe response out
// reads answer exactly 3 cycles after i_req, writes get no answer
// a request may arrive on every cycle, nothing ever stalls
// o_irq[k] is high while queue k holds at least one word

module mbox_top (
	input  logic                            i_core_clk,
	input  logic                            i_rst_n,
	input  logic                            i_req,
	input  logic                            i_we,
	input  mbox_pkg::addr_t                 i_addr,
	input  mbox_pkg::data_t                 i_wdata,
	output logic                            o_rsp_valid,
	output mbox_pkg::data_t                 o_rsp_data,
	output logic                            o_rsp_err,
	output logic [mbox_pkg::NUM_QUEUES-1:0] o_irq
);

	logic [mbox_pkg::NUM_QUEUES-1:0]            push;
	logic [mbox_pkg::NUM_QUEUES-1:0]            pop;
	logic [mbox_pkg::NUM_QUEUES-1:0]            stat_rd;
	mbox_pkg::data_t                            wdata;
	logic                                       dec_err;
	logic [mbox_pkg::NUM_QUEUES-1:0]            rd_valid;
	mbox_pkg::data_t [mbox_pkg::NUM_QUEUES-1:0] rd_data;
	logic [mbox_pkg::NUM_QUEUES-1:0]            rd_err;

	bus_decode u_decode (
		.i_core_clk (i_core_clk),
		.i_rst_n    (i_rst_n),
		.i_req      (i_req),
		.i_we       (i_we),
		.i_addr     (i_addr),
		.i_wdata    (i_wdata),
		.o_push     (push),
		.o_pop      (pop),
		.o_stat_rd  (stat_rd),
		.o_wdata    (wdata),
		.o_dec_err  (dec_err)
	);

	// one queue per window
	for (genvar g = 0; g < mbox_pkg::NUM_QUEUES; g++) begin : gen_queue
		msg_queue u_queue (
			.i_core_clk (i_core_clk),
			.i_rst_n    (i_rst_n),
			.i_push     (push[g]),
			.i_pop      (pop[g]),
			.i_stat_rd  (stat_rd[g]),
			.i_wdata    (wdata),
			.o_rd_valid (rd_valid[g]),
			.o_rd_data  (rd_data[g]),
			.o_rd_err   (rd_err[g]),
			.o_irq      (o_irq[g])
		);
	end

	rsp_collect u_collect (
		.i_core_clk  (i_core_clk),
		.i_rst_n     (i_rst_n),
		.i_rd_valid  (rd_valid),
		.i_rd_data   (rd_data),
		.i_rd_err    (rd_err),
		.i_dec_err   (dec_err),
		.o_rsp_valid (o_rsp_valid),
		.o_rsp_data  (o_rsp_data),
		.o_rsp_err   (o_rsp_err)
	);

endmodule

//--- msg_queue.sv
// one mailbox message queue, QUEUE_DEPTH words deep
// expects at most one of push, pop and stat_rd per cycle
// push to a full queue is dropped and sets the sticky overflow flag
// status reads return {ovf, count} as they stood, then clear ovf
// o_irq is registered and lags the count by one cycle

module msg_queue (
	input  logic            i_core_clk,
	input  logic            i_rst_n,
	input  logic            i_push,
	input  logic            i_pop,
	input  logic            i_stat_rd,
	input  mbox_pkg::data_t i_wdata,
	output logic            o_rd_valid,
	output mbox_pkg::data_t o_rd_data,
	output logic            o_rd_err,
	output logic            o_irq
);

	mbox_pkg::data_t mem [mbox_pkg::QUEUE_DEPTH];

	logic [mbox_pkg::PTR_W-1:0] wr_ptr;
	logic [mbox_pkg::PTR_W-1:0] rd_ptr;
	mbox_pkg::count_t           count;
	logic                       ovf;

	logic            full;
	logic            empty;
	logic            do_push;
	logic            do_pop;
	mbox_pkg::data_t stat_word;

	assign full    = (count == mbox_pkg::count_t'(mbox_pkg::QUEUE_DEPTH));
	assign empty   = (count == '0);
	assign do_push = i_push && !full;
	assign do_pop  = i_pop && !empty;

	// status word with the count in the low bits and ovf on top
	always_comb begin
		stat_word = '0;
		stat_word[mbox_pkg::CNT_W-1:0] = count;
		stat_word[mbox_pkg::STAT_OVF_BIT] = ovf;
	end

	// storage write
	always_ff @(posedge i_core_clk) begin
		if (do_push) begin
			mem[wr_ptr] <= i_wdata;
		end
	end

	// pointers and fill count
	always_ff @(posedge i_core_clk) begin
		if (!i_rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == mbox_pkg::PTR_LAST) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == mbox_pkg::PTR_LAST) ? '0 : rd_ptr + 1'b1;
			end
			// push and pop never arrive together
			if (do_push) begin
				count <= count + 1'b1;
			end else if (do_pop) begin
				count <= count - 1'b1;
			end
		end
	end

	// sticky overflow cleared by a status read
	always_ff @(posedge i_core_clk) begin
		if (!i_rst_n) begin
			ovf <= 1'b0;
		end else if (i_push && full) begin
			ovf <= 1'b1;
		end else if (i_stat_rd) begin
			ovf <= 1'b0;
		end
	end

	// read result control
	always_ff @(posedge i_core_clk) begin
		if (!i_rst_n) begin
			o_rd_valid <= 1'b0;
			o_rd_err   <= 1'b0;
		end else begin
			o_rd_valid <= i_pop || i_stat_rd;
			// popping an empty queue is the only failing read
			o_rd_err   <= i_pop && empty;
		end
	end

	// read result data
	always_ff @(posedge i_core_clk) begin
		if (i_stat_rd) begin
			o_rd_data <= stat_word;
		end else if (do_pop) begin
			o_rd_data <= mem[rd_ptr];
		end else if (i_pop) begin
			o_rd_data <= '0;
		end
	end

	// interrupt while there is anything to read
	always_ff @(posedge i_core_clk) begin
		if (!i_rst_n) begin
			o_irq <= 1'b0;
		end else begin
			o_irq <= !empty;
		end
	end

	a_count_range: assert property (@(posedge i_core_clk) disable iff (!i_rst_n)
		count <= mbox_pkg::count_t'(mbox_pkg::QUEUE_DEPTH));

	// the decoder must keep the three operations apart
	a_one_op: assert property (@(posedge i_core_clk) disable iff (!i_rst_n)
		$onehot0({i_push, i_pop, i_stat_rd}));

endmodule

//--- project.f
mbox_pkg.sv
bus_decode.sv
msg_queue.sv
rsp_collect.sv
mbox_top.sv
tb_checker.sv
tb_mbox.sv

//--- rsp_collect.sv
// merges queue read results and decode errors into one response port
// decode errors are one stage ahead of queue results and are delayed here
// sources are exclusive by construction, so the merge is a plain OR
// o_rsp_data is 0 on errors since the sources already return 0 then

module rsp_collect (
	input  logic                                    i_core_clk,
	input  logic                                    i_rst_n,
	input  logic [mbox_pkg::NUM_QUEUES-1:0]         i_rd_valid,
	input  mbox_pkg::data_t [mbox_pkg::NUM_QUEUES-1:0] i_rd_data,
	input  logic [mbox_pkg::NUM_QUEUES-1:0]         i_rd_err,
	input  logic                                    i_dec_err,
	output logic                                    o_rsp_valid,
	output mbox_pkg::data_t                         o_rsp_data,
	output logic                                    o_rsp_err
);

	logic            dec_err_q;
	logic            mrg_valid;
	logic            mrg_err;
	mbox_pkg::data_t mrg_data;

	// line the decode error up with the queue stage
	always_ff @(posedge i_core_clk) begin
		if (!i_rst_n) begin
			dec_err_q <= 1'b0;
		end else begin
			dec_err_q <= i_dec_err;
		end
	end

	always_comb begin
		mrg_data = '0;
		for (int k = 0; k < mbox_pkg::NUM_QUEUES; k++) begin
			if (i_rd_valid[k]) begin
				mrg_data = mrg_data | i_rd_data[k];
			end
		end
	end

	assign mrg_valid = (|i_rd_valid) || dec_err_q;
	assign mrg_err   = (|(i_rd_valid & i_rd_err)) || dec_err_q;

	always_ff @(posedge i_core_clk) begin
		if (!i_rst_n) begin
			o_rsp_valid <= 1'b0;
			o_rsp_err   <= 1'b0;
		end else begin
			o_rsp_valid <= mrg_valid;
			o_rsp_err   <= mrg_err;
		end
	end

	always_ff @(posedge i_core_clk) begin
		o_rsp_data <= mrg_data;
	end

	// decoder and queues together never answer twice in one cycle
	a_one_source: assert property (@(posedge i_core_clk) disable iff (!i_rst_n)
		$onehot0({i_rd_valid, dec_err_q}));

endmodule

//--- run.sh
#!/usr/bin/env bash
# builds the mailbox testbench with Verilator and runs it
# the run passes only if the pass message shows up in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f project.f --top-module tb_mbox -o tb_mbox \
	&& ./obj_dir/tb_mbox | tee /dev/stderr | grep "Testbench passed" > /dev/null \
	&& { echo "simulation result: pass"; exit 0; } \
	|| { echo "simulation result: fail"; exit 1; }

//--- tb_checker.sv
// watches the mailbox ports and checks every response against a model
// the model applies each request at the edge where the DUT samples it
// responses and o_irq are due exactly 3 edges after that request
// table reads also carry a fixed expected value that is checked as well

module tb_checker (
	input  logic                            i_core_clk,
	input  logic                            i_rst_n,
	input  logic                            i_req,
	input  logic                            i_we,
	input  mbox_pkg::addr_t                 i_addr,
	input  mbox_pkg::data_t                 i_wdata,
	input  logic                            i_rsp_valid,
	input  mbox_pkg::data_t                 i_rsp_data,
	input  logic                            i_rsp_err,
	input  logic [mbox_pkg::NUM_QUEUES-1:0] i_irq,
	input  logic                            i_tbl_chk,
	input  mbox_pkg::data_t                 i_tbl_data,
	input  logic                            i_tbl_err,
	output int                              o_value_errs,
	output int                              o_proto_errs,
	output int                              o_rsp_seen
);

	localparam int LAT = 3;

	mbox_pkg::data_t model_q [mbox_pkg::NUM_QUEUES][$];
	logic            model_ovf [mbox_pkg::NUM_QUEUES];

	// expected outputs, slot LAT-1 is due at the current edge
	logic                            p_valid [LAT];
	mbox_pkg::data_t                 p_data [LAT];
	logic                            p_err [LAT];
	logic [mbox_pkg::NUM_QUEUES-1:0] p_irq [LAT];
	logic                            t_chk [LAT];
	mbox_pkg::data_t                 t_data [LAT];
	logic                            t_err [LAT];

	int value_errs = 0;
	int proto_errs = 0;
	int rsp_seen   = 0;

	assign o_value_errs = value_errs;
	assign o_proto_errs = proto_errs;
	assign o_rsp_seen   = rsp_seen;

	function automatic void report_mismatch(input string name, input logic [31:0] exp,
			input logic [31:0] got);
		$display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, got);
		value_errs++;
	endfunction

	// one request on the reference queues, returns the predicted response
	task automatic apply_request(output logic v, output mbox_pkg::data_t d, output logic e);
		int              hit;
		logic            stat;
		mbox_pkg::addr_t base;
		hit  = -1;
		stat = 1'b0;
		v    = 1'b0;
		d    = '0;
		e    = 1'b0;
		for (int k = 0; k < mbox_pkg::NUM_QUEUES; k++) begin
			base = mbox_pkg::MBOX_BASE + mbox_pkg::QUEUE_STRIDE * k;
			if (i_addr == base + mbox_pkg::OFS_DATA) begin
				hit = k;
			end
			if (i_addr == base + mbox_pkg::OFS_STAT) begin
				hit  = k;
				stat = 1'b1;
			end
		end
		if (i_we) begin
			if (hit >= 0 && !stat) begin
				if (model_q[hit].size() == mbox_pkg::QUEUE_DEPTH) begin
					model_ovf[hit] = 1'b1;
				end else begin
					model_q[hit].push_back(i_wdata);
				end
			end
		end else begin
			v = 1'b1;
			if (hit < 0) begin
				e = 1'b1;
			end else if (stat) begin
				d[mbox_pkg::CNT_W-1:0] = mbox_pkg::count_t'(model_q[hit].size());
				d[31] = model_ovf[hit];
				model_ovf[hit] = 1'b0;
			end else if (model_q[hit].size() == 0) begin
				e = 1'b1;
			end else begin
				d = model_q[hit].pop_front();
			end
		end
	endtask

	task automatic check_due();
		if (i_irq !== p_irq[LAT-1]) begin
			report_mismatch("o_irq", 32'(p_irq[LAT-1]), 32'(i_irq));
		end
		if (p_valid[LAT-1] && i_rsp_valid !== 1'b1) begin
			$display("Error at %0t: a read response was due but o_rsp_valid stayed low", $time);
			proto_errs++;
		end else if (!p_valid[LAT-1] && i_rsp_valid !== 1'b0) begin
			$display("Error at %0t: o_rsp_valid went high with no read outstanding", $time);
			proto_errs++;
		end else if (p_valid[LAT-1]) begin
			rsp_seen++;
			if (i_rsp_data !== p_data[LAT-1]) begin
				report_mismatch("o_rsp_data", p_data[LAT-1], i_rsp_data);
			end
			if (i_rsp_err !== p_err[LAT-1]) begin
				report_mismatch("o_rsp_err", 32'(p_err[LAT-1]), 32'(i_rsp_err));
			end
			if (t_chk[LAT-1] && i_rsp_data !== t_data[LAT-1]) begin
				report_mismatch("o_rsp_data (table)", t_data[LAT-1], i_rsp_data);
			end
			if (t_chk[LAT-1] && i_rsp_err !== t_err[LAT-1]) begin
				report_mismatch("o_rsp_err (table)", 32'(t_err[LAT-1]), 32'(i_rsp_err));
			end
		end
	endtask

	always @(posedge i_core_clk) begin
		logic                            nv;
		mbox_pkg::data_t                 nd;
		logic                            ne;
		logic [mbox_pkg::NUM_QUEUES-1:0] ni;
		if (!i_rst_n) begin
			for (int k = 0; k < mbox_pkg::NUM_QUEUES; k++) begin
				model_q[k].delete();
				model_ovf[k] = 1'b0;
			end
			for (int s = 0; s < LAT; s++) begin
				p_valid[s] = 1'b0;
				p_data[s]  = '0;
				p_err[s]   = 1'b0;
				p_irq[s]   = '0;
				t_chk[s]   = 1'b0;
				t_data[s]  = '0;
				t_err[s]   = 1'b0;
			end
		end else begin
			check_due();
			nv = 1'b0;
			nd = '0;
			ne = 1'b0;
			if (i_req) begin
				apply_request(nv, nd, ne);
			end
			// irq is high while a queue holds anything
			for (int k = 0; k < mbox_pkg::NUM_QUEUES; k++) begin
				ni[k] = (model_q[k].size() != 0);
			end
			for (int s = LAT - 1; s > 0; s--) begin
				p_valid[s] = p_valid[s-1];
				p_data[s]  = p_data[s-1];
				p_err[s]   = p_err[s-1];
				p_irq[s]   = p_irq[s-1];
				t_chk[s]   = t_chk[s-1];
				t_data[s]  = t_data[s-1];
				t_err[s]   = t_err[s-1];
			end
			p_valid[0] = nv;
			p_data[0]  = nd;
			p_err[0]   = ne;
			p_irq[0]   = ni;
			t_chk[0]   = i_req && !i_we && i_tbl_chk;
			t_data[0]  = i_tbl_data;
			t_err[0]   = i_tbl_err;
		end
	end

endmodule

//--- tb_mbox.sv
// testbench top for the two-queue mailbox
// runs a fixed request table, then a seeded random run of queue traffic
// inputs change 10 time units after the rising edge, one request per cycle
// tb_checker does all comparing, this module drives and reports

module tb_mbox;

	localparam int PERIOD     = 100;
	localparam int DRIVE_DLY  = 10;
	localparam int RST_CYCLES = 16;
	localparam int RAND_OPS   = 200;

	localparam mbox_pkg::addr_t Q0_DATA  = 32'hF100_1000;
	localparam mbox_pkg::addr_t Q0_STAT  = 32'hF100_1004;
	localparam mbox_pkg::addr_t Q1_DATA  = 32'hF100_2000;
	localparam mbox_pkg::addr_t Q1_STAT  = 32'hF100_2004;
	localparam mbox_pkg::addr_t UNMAPPED = 32'hF100_1008;

	typedef struct packed {
		logic            req;
		logic            we;
		mbox_pkg::addr_t addr;
		mbox_pkg::data_t wdata;
		mbox_pkg::data_t exp_data;
		logic            exp_err;
	} row_t;

	logic                            core_clk;
	logic                            rst_n;
	logic                            req;
	logic                            we;
	mbox_pkg::addr_t                 addr;
	mbox_pkg::data_t                 wdata;
	logic                            rsp_valid;
	mbox_pkg::data_t                 rsp_data;
	logic                            rsp_err;
	logic [mbox_pkg::NUM_QUEUES-1:0] irq;
	logic                            tbl_chk;
	mbox_pkg::data_t                 tbl_data;
	logic                            tbl_err;
	int                              value_errs;
	int                              proto_errs;
	int                              rsp_seen;

	row_t   stim [$];
	bit     table_ready = 1'b0;
	integer seed;

	initial core_clk = 1'b0;
	always #(PERIOD / 2) core_clk = ~core_clk;

	mbox_top i_dut (
		.i_core_clk  (core_clk),
		.i_rst_n     (rst_n),
		.i_req       (req),
		.i_we        (we),
		.i_addr      (addr),
		.i_wdata     (wdata),
		.o_rsp_valid (rsp_valid),
		.o_rsp_data  (rsp_data),
		.o_rsp_err   (rsp_err),
		.o_irq       (irq)
	);

	tb_checker u_checker (
		.i_core_clk   (core_clk),
		.i_rst_n      (rst_n),
		.i_req        (req),
		.i_we         (we),
		.i_addr       (addr),
		.i_wdata      (wdata),
		.i_rsp_valid  (rsp_valid),
		.i_rsp_data   (rsp_data),
		.i_rsp_err    (rsp_err),
		.i_irq        (irq),
		.i_tbl_chk    (tbl_chk),
		.i_tbl_data   (tbl_data),
		.i_tbl_err    (tbl_err),
		.o_value_errs (value_errs),
		.o_proto_errs (proto_errs),
		.o_rsp_seen   (rsp_seen)
	);

	task automatic add_row(input logic r, input logic w, input mbox_pkg::addr_t a,
			input mbox_pkg::data_t d, input mbox_pkg::data_t ed, input logic ee);
		row_t row;
		row.req      = r;
		row.we       = w;
		row.addr     = a;
		row.wdata    = d;
		row.exp_data = ed;
		row.exp_err  = ee;
		stim.push_back(row);
	endtask

	task automatic add_write(input mbox_pkg::addr_t a, input mbox_pkg::data_t d);
		add_row(1'b1, 1'b1, a, d, '0, 1'b0);
	endtask

	task automatic add_read(input mbox_pkg::addr_t a, input mbox_pkg::data_t ed, input logic ee);
		add_row(1'b1, 1'b0, a, '0, ed, ee);
	endtask

	task automatic add_idle(input int n);
		repeat (n) add_row(1'b0, 1'b0, '0, '0, '0, 1'b0);
	endtask

	task automatic build_table();
		// push then status read on the next cycle, queues kept apart
		add_read(Q0_STAT, 32'h0, 1'b0);
		add_write(Q0_DATA, 32'h1111_1111);
		add_write(Q0_DATA, 32'h2222_2222);
		add_write(Q0_DATA, 32'h3333_3333);
		add_read(Q0_STAT, 32'h3, 1'b0);
		add_write(Q1_DATA, 32'hA1A1_A1A1);
		add_read(Q1_STAT, 32'h1, 1'b0);
		add_idle(3);
		add_read(Q0_DATA, 32'h1111_1111, 1'b0);
		add_read(Q1_DATA, 32'hA1A1_A1A1, 1'b0);
		add_read(Q0_DATA, 32'h2222_2222, 1'b0);
		add_read(Q0_DATA, 32'h3333_3333, 1'b0);
		// empty pop
		add_read(Q0_DATA, 32'h0, 1'b1);
		add_read(Q1_STAT, 32'h0, 1'b0);
		add_idle(4);
		// unmapped read, and writes that must change nothing
		add_read(UNMAPPED, 32'h0, 1'b1);
		add_write(UNMAPPED, 32'hDEAD_0001);
		add_write(Q0_STAT, 32'hBEEF_0002);
		add_read(Q0_STAT, 32'h0, 1'b0);
		// ninth push overflows, flag reads once then clears
		for (int i = 0; i < 9; i++) begin
			add_write(Q1_DATA, 32'h5000_0000 + 32'(i));
		end
		add_read(Q1_STAT, 32'h8000_0008, 1'b0);
		add_read(Q1_STAT, 32'h0000_0008, 1'b0);
		for (int i = 0; i < 8; i++) begin
			add_read(Q1_DATA, 32'h5000_0000 + 32'(i), 1'b0);
		end
		add_read(Q1_STAT, 32'h0, 1'b0);
		add_idle(4);
	endtask

	task automatic drive(input logic r, input logic w, input mbox_pkg::addr_t a,
			input mbox_pkg::data_t d, input logic chk, input mbox_pkg::data_t ed,
			input logic ee);
		@(posedge core_clk);
		#DRIVE_DLY;
		req      = r;
		we       = w;
		addr     = a;
		wdata    = d;
		tbl_chk  = chk;
		tbl_data = ed;
		tbl_err  = ee;
	endtask

	task automatic random_op();
		logic [31:0]     r;
		mbox_pkg::data_t d;
		mbox_pkg::addr_t base;
		r    = $random(seed);
		d    = $random(seed);
		base = r[4] ? Q1_DATA : Q0_DATA;
		case (r[2:0])
			3'd0, 3'd1, 3'd2: drive(1'b1, 1'b1, base, d, 1'b0, '0, 1'b0);
			3'd3, 3'd4, 3'd5: drive(1'b1, 1'b0, base, '0, 1'b0, '0, 1'b0);
			3'd6: drive(1'b1, 1'b0, base + 32'h4, '0, 1'b0, '0, 1'b0);
			default: drive(1'b0, 1'b0, '0, '0, 1'b0, '0, 1'b0);
		endcase
	endtask

	initial begin
		seed     = 32'h7580_bda2;
		rst_n    = 1'b0;
		req      = 1'b0;
		we       = 1'b0;
		addr     = '0;
		wdata    = '0;
		tbl_chk  = 1'b0;
		tbl_data = '0;
		tbl_err  = 1'b0;
		build_table();
		table_ready = 1'b1;
		repeat (RST_CYCLES) @(posedge core_clk);
		#DRIVE_DLY;
		rst_n = 1'b1;
		foreach (stim[i]) begin
			drive(stim[i].req, stim[i].we, stim[i].addr, stim[i].wdata,
				stim[i].req && !stim[i].we, stim[i].exp_data, stim[i].exp_err);
		end
		repeat (RAND_OPS) random_op();
		drive(1'b0, 1'b0, '0, '0, 1'b0, '0, 1'b0);
		// let the last responses and irq updates drain
		repeat (6) @(posedge core_clk);
		if (rsp_seen == 0) begin
			$display("Error: no read responses were checked during the run");
		end
		$display("errors: %0d wrong values, %0d missing or extra responses, %0d responses checked",
			value_errs, proto_errs, rsp_seen);
		if (value_errs == 0 && proto_errs == 0 && rsp_seen > 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

	// watchdog sized from reset, table and random run
	initial begin
		wait (table_ready);
		#((RST_CYCLES + stim.size() + RAND_OPS + 50) * PERIOD);
		$display("timeout: the run did not reach its end in time");
		$display("Testbench failed");
		$finish;
	end

endmodule
